/* project.f */
logic/fetch_pkg.sv
logic/warp_tag_store.sv
logic/ibuf_credit_counter.sv
logic/fetch_req_buffer.sv
logic/fetch_unit.sv
logic/instr_mem.sv
logic/fetch_top.sv
verif/fetch_props.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* instr.hex */
// One 32-bit instruction word per line, word addresses 0 to 15
00000013
00a00093
00108113
002081b3
40110233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
4020d533
0000a5b7
00c0066f
00b50023
00052683
fe0718e3

/* verif/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    typedef struct packed {
        fetch_pkg::pc_t    pc;
        fetch_pkg::tmask_t tmask;
        fetch_pkg::wid_t   wid;
        fetch_pkg::uuid_t  uuid;
    } sched_rec_t;

    logic                            clk;
    logic                            rst_n;
    logic                            sched_valid;
    fetch_pkg::pc_t                  sched_pc;
    fetch_pkg::tmask_t               sched_tmask;
    fetch_pkg::wid_t                 sched_wid;
    fetch_pkg::uuid_t                sched_uuid;
    logic                            sched_ready;
    logic                            fetch_valid;
    fetch_pkg::instr_t               fetch_instr;
    fetch_pkg::pc_t                  fetch_pc;
    fetch_pkg::tmask_t               fetch_tmask;
    fetch_pkg::wid_t                 fetch_wid;
    fetch_pkg::uuid_t                fetch_uuid;
    logic                            fetch_ready;
    logic [fetch_pkg::ISSUE_CNT-1:0] ibuf_pop;

    fetch_pkg::instr_t               image [fetch_pkg::IMEM_DEPTH];
    sched_rec_t                      expq [$];
    sched_rec_t                      rec;
    logic [fetch_pkg::NUM_WARPS-1:0] busy;
    // Delivered instructions not yet popped in each slice
    int                              held [fetch_pkg::ISSUE_CNT];
    int                              checks;
    int                              errors;
    int                              test_errors;
    logic [15:0]                     lfsr;
    fetch_pkg::uuid_t                next_uuid;
    logic                            acc;
    logic                            timed_out;

    fetch_top u_fetch_top (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic fetch_pkg::instr_t ref_instr(input fetch_pkg::pc_t pc);
        return image[pc[5:2]];
    endfunction

    // Taps 16, 14, 13, 11
    function logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[6:0], lfsr_bit()};
        return v;
    endfunction

    task check_instr(input fetch_pkg::instr_t got, input fetch_pkg::instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: instr got %h expected %h", $time, got, exp);
        end
    endtask

    task check_pc(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: pc got %h expected %h", $time, got, exp);
        end
    endtask

    task check_tmask(input fetch_pkg::tmask_t got, input fetch_pkg::tmask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: tmask got %b expected %b", $time, got, exp);
        end
    endtask

    task check_wid(input fetch_pkg::wid_t got, input fetch_pkg::wid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: wid got %0d expected %0d", $time, got, exp);
        end
    endtask

    task check_uuid(input fetch_pkg::uuid_t got, input fetch_pkg::uuid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: uuid got %h expected %h", $time, got, exp);
        end
    endtask

    task check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Later waits give up at once after the first timeout
    task report_timeout(input string what);
        if (!timed_out) begin
            errors++;
            $display("Timeout at %0t while waiting for %s", $time, what);
        end
        timed_out = 1'b1;
    endtask

    task finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Record acceptances and compare every fetch transfer
    always @(posedge clk) begin
        if (rst_n) begin
            if (sched_valid && sched_ready) begin
                rec = '{pc: sched_pc, tmask: sched_tmask, wid: sched_wid, uuid: sched_uuid};
                expq.push_back(rec);
                busy[sched_wid] = 1'b1;
            end
            if (fetch_valid && fetch_ready) begin
                if (expq.size() == 0) begin
                    errors++;
                    $display("Fetch output at %0t with no accepted schedule", $time);
                end else begin
                    rec = expq.pop_front();
                    check_instr(fetch_instr, ref_instr(rec.pc));
                    check_pc(fetch_pc, rec.pc);
                    check_tmask(fetch_tmask, rec.tmask);
                    check_wid(fetch_wid, rec.wid);
                    check_uuid(fetch_uuid, rec.uuid);
                    busy[rec.wid] = 1'b0;
                    held[rec.wid[0]]++;
                end
            end
            for (int s = 0; s < fetch_pkg::ISSUE_CNT; s++) begin
                if (ibuf_pop[s]) held[s]--;
            end
        end
    end

    // Offer a schedule for up to max_cycles and report whether it was taken
    task automatic try_sched(input fetch_pkg::wid_t w, input fetch_pkg::pc_t pc,
                             input fetch_pkg::tmask_t tm, input int max_cycles,
                             output logic taken);
        int n;
        n           = 0;
        taken       = 1'b0;
        sched_valid = 1'b1;
        sched_wid   = w;
        sched_pc    = pc;
        sched_tmask = tm;
        sched_uuid  = next_uuid;
        while (!taken && n < max_cycles && !timed_out) begin
            @(posedge clk);
            taken = sched_ready;
            n++;
        end
        if (taken) next_uuid++;
        #1 sched_valid = 1'b0;
    endtask

    task automatic sched_one(input fetch_pkg::wid_t w, input fetch_pkg::pc_t pc,
                             input fetch_pkg::tmask_t tm);
        logic taken;
        try_sched(w, pc, tm, 200, taken);
        if (!taken) report_timeout("schedule acceptance");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expq.size() != 0 && !timed_out) begin
            @(posedge clk);
            #1 n++;
            if (n > 500) report_timeout("outstanding fetches to return");
        end
    endtask

    // Model the instruction buffer emptying every delivered entry
    task automatic release_credits();
        int n;
        n = 0;
        wait_drain();
        ibuf_pop = {held[1] > 0, held[0] > 0};
        while (ibuf_pop != '0 && !timed_out) begin
            @(posedge clk);
            #1 ibuf_pop = {held[1] > 0, held[0] > 0};
            n++;
            if (n > 50) report_timeout("credit release");
        end
        ibuf_pop = '0;
    endtask

    task automatic random_traffic(input int cycles);
        logic            fired;
        fetch_pkg::wid_t w;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            fired = sched_valid && sched_ready;
            #1;
            if (fired) begin
                next_uuid++;
                sched_valid = 1'b0;
            end
            if (!sched_valid && rand_bits(1) != 0) begin
                w = fetch_pkg::wid_t'(rand_bits(2));
                if (!busy[w]) begin
                    sched_wid   = w;
                    sched_pc    = {22'h4, rand_bits(8), 2'b00};
                    sched_tmask = fetch_pkg::tmask_t'(rand_bits(4));
                    sched_uuid  = next_uuid;
                    sched_valid = 1'b1;
                end
            end
            fetch_ready = (rand_bits(2) != 0);
            for (int s = 0; s < fetch_pkg::ISSUE_CNT; s++) begin
                ibuf_pop[s] = (held[s] > 0) && (rand_bits(1) != 0);
            end
        end
        @(posedge clk);
        fired = sched_valid && sched_ready;
        #1;
        if (fired) next_uuid++;
        sched_valid = 1'b0;
        fetch_ready = 1'b1;
        ibuf_pop    = '0;
    endtask

    initial begin
        rst_n       = 1'b0;
        sched_valid = 1'b0;
        sched_pc    = '0;
        sched_tmask = '0;
        sched_wid   = '0;
        sched_uuid  = '0;
        fetch_ready = 1'b1;
        ibuf_pop    = '0;
        busy        = '0;
        held        = '{default: 0};
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        lfsr        = 16'd81;
        next_uuid   = '0;
        timed_out   = 1'b0;
        $readmemh("instr.hex", image);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        check_flag("fetch_valid after reset", fetch_valid, 1'b0);
        check_flag("sched_ready after reset", sched_ready, 1'b1);
        finish_test("reset");

        for (int w = 0; w < fetch_pkg::NUM_WARPS; w++) begin
            sched_one(fetch_pkg::wid_t'(w), 32'h100 + 32'(w * 12), fetch_pkg::tmask_t'(w + 9));
            wait_drain();
        end
        release_credits();
        finish_test("single");

        // Slice 0 holds warps 0 and 2
        sched_one(2'd0, 32'h204, 4'hf);
        sched_one(2'd2, 32'h208, 4'h3);
        wait_drain();
        try_sched(2'd0, 32'h20c, 4'h1, 10, acc);
        check_flag("slice 0 accepted past credit limit", acc, 1'b0);
        sched_one(2'd1, 32'h210, 4'h7);
        ibuf_pop = 2'b01;
        @(posedge clk);
        #1 ibuf_pop = '0;
        sched_one(2'd0, 32'h214, 4'h8);
        release_credits();
        finish_test("credit");

        fetch_ready = 1'b0;
        sched_one(2'd0, 32'h33c, 4'h1);
        sched_one(2'd1, 32'h320, 4'h2);
        sched_one(2'd2, 32'h318, 4'h4);
        repeat (20) @(posedge clk);
        #1;
        try_sched(2'd3, 32'h304, 4'h8, 5, acc);
        check_flag("accepted with full request buffer", acc, 1'b0);
        fetch_ready = 1'b1;
        sched_one(2'd3, 32'h304, 4'h8);
        release_credits();
        finish_test("backpressure");

        random_traffic(400);
        release_credits();
        finish_test("random");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verif/fetch_props.sv */
`timescale 1ns/1ps

module fetch_props (
    input logic                clk,
    input logic                rst_n,
    input logic                sched_valid,
    input fetch_pkg::pc_t      sched_pc,
    input logic                fetch_valid,
    input logic                fetch_ready,
    input fetch_pkg::instr_t   fetch_instr,
    input fetch_pkg::pc_t      fetch_pc,
    input fetch_pkg::tmask_t   fetch_tmask,
    input fetch_pkg::wid_t     fetch_wid,
    input fetch_pkg::uuid_t    fetch_uuid,
    input fetch_pkg::credit_t  credit0,
    input fetch_pkg::credit_t  credit1
);

    a_pc_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        sched_valid |-> sched_pc != '0)
        else $error("Schedule offered with a zero PC");

    // A stalled fetch keeps its payload
    a_fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_ready |=> fetch_valid &&
        $stable({fetch_instr, fetch_pc, fetch_tmask, fetch_wid, fetch_uuid}))
        else $error("Fetch output changed while stalled");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit0 <= fetch_pkg::credit_t'(fetch_pkg::IBUF_SIZE) &&
        credit1 <= fetch_pkg::credit_t'(fetch_pkg::IBUF_SIZE))
        else $error("Slice credit count above buffer size");

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !fetch_valid)
        else $error("fetch_valid high during reset");

endmodule

bind fetch_unit fetch_props u_fetch_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .sched_valid (sched_valid),
    .sched_pc    (sched_pc),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .fetch_tmask (fetch_tmask),
    .fetch_wid   (fetch_wid),
    .fetch_uuid  (fetch_uuid),
    .credit0     (g_credit[0].u_credit.count),
    .credit1     (g_credit[1].u_credit.count)
);

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sched_valid,
    input  fetch_pkg::pc_t                  sched_pc,
    input  fetch_pkg::tmask_t               sched_tmask,
    input  fetch_pkg::wid_t                 sched_wid,
    input  fetch_pkg::uuid_t                sched_uuid,
    output logic                            sched_ready,
    output logic                            fetch_valid,
    output fetch_pkg::instr_t               fetch_instr,
    output fetch_pkg::pc_t                  fetch_pc,
    output fetch_pkg::tmask_t               fetch_tmask,
    output fetch_pkg::wid_t                 fetch_wid,
    output fetch_pkg::uuid_t                fetch_uuid,
    input  logic                            fetch_ready,
    input  logic [fetch_pkg::ISSUE_CNT-1:0] ibuf_pop
);

    // Internal instruction memory bus
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    fetch_pkg::imem_addr_t mem_req_addr;
    fetch_pkg::imem_tag_t  mem_req_tag;
    logic                  mem_rsp_valid;
    fetch_pkg::instr_t     mem_rsp_data;
    fetch_pkg::imem_tag_t  mem_rsp_tag;
    logic                  mem_rsp_ready;

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .sched_valid   (sched_valid),
        .sched_pc      (sched_pc),
        .sched_tmask   (sched_tmask),
        .sched_wid     (sched_wid),
        .sched_uuid    (sched_uuid),
        .sched_ready   (sched_ready),
        .fetch_valid   (fetch_valid),
        .fetch_instr   (fetch_instr),
        .fetch_pc      (fetch_pc),
        .fetch_tmask   (fetch_tmask),
        .fetch_wid     (fetch_wid),
        .fetch_uuid    (fetch_uuid),
        .fetch_ready   (fetch_ready),
        .ibuf_pop      (ibuf_pop),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready)
    );

    instr_mem u_instr_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready)
    );

endmodule

/* logic/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req_valid,
    output logic                  mem_req_ready,
    input  fetch_pkg::imem_addr_t mem_req_addr,
    input  fetch_pkg::imem_tag_t  mem_req_tag,
    output logic                  mem_rsp_valid,
    output fetch_pkg::instr_t     mem_rsp_data,
    output fetch_pkg::imem_tag_t  mem_rsp_tag,
    input  logic                  mem_rsp_ready
);

    fetch_pkg::instr_t rom [fetch_pkg::IMEM_DEPTH];
    logic              req_fire;

    initial begin
        $readmemh("instr.hex", rom);
    end

    // Accept when the response register is empty or draining
    assign mem_req_ready = !mem_rsp_valid || mem_rsp_ready;
    assign req_fire      = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rsp_valid <= 1'b0;
        end else if (req_fire) begin
            mem_rsp_valid <= 1'b1;
        end else if (mem_rsp_ready) begin
            mem_rsp_valid <= 1'b0;
        end
    end

    // Only the low address bits index the ROM
    always_ff @(posedge clk) begin
        if (req_fire) begin
            mem_rsp_data <= rom[mem_req_addr[fetch_pkg::IMEM_IDX_W-1:0]];
            mem_rsp_tag  <= mem_req_tag;
        end
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    // Schedule port
    input  logic                                sched_valid,
    input  fetch_pkg::pc_t                      sched_pc,
    input  fetch_pkg::tmask_t                   sched_tmask,
    input  fetch_pkg::wid_t                     sched_wid,
    input  fetch_pkg::uuid_t                    sched_uuid,
    output logic                                sched_ready,
    // Fetch port
    output logic                                fetch_valid,
    output fetch_pkg::instr_t                   fetch_instr,
    output fetch_pkg::pc_t                      fetch_pc,
    output fetch_pkg::tmask_t                   fetch_tmask,
    output fetch_pkg::wid_t                     fetch_wid,
    output fetch_pkg::uuid_t                    fetch_uuid,
    input  logic                                fetch_ready,
    input  logic [fetch_pkg::ISSUE_CNT-1:0]     ibuf_pop,
    // Instruction memory bus
    output logic                                mem_req_valid,
    input  logic                                mem_req_ready,
    output fetch_pkg::imem_addr_t               mem_req_addr,
    output fetch_pkg::imem_tag_t                mem_req_tag,
    input  logic                                mem_rsp_valid,
    input  fetch_pkg::instr_t                   mem_rsp_data,
    input  fetch_pkg::imem_tag_t                mem_rsp_tag,
    output logic                                mem_rsp_ready
);

    fetch_pkg::isw_t               sched_isw;
    logic [fetch_pkg::ISSUE_CNT-1:0] slice_full;
    logic                          ibuf_ready;
    logic                          buf_in_ready;
    logic                          sched_fire;
    fetch_pkg::wid_t               rsp_wid;

    // Slice is the low bits of the warp id
    assign sched_isw  = fetch_pkg::isw_t'(sched_wid);
    assign ibuf_ready = !slice_full[sched_isw];

    assign sched_ready = buf_in_ready && ibuf_ready;
    assign sched_fire  = sched_valid && sched_ready;

    for (genvar i = 0; i < fetch_pkg::ISSUE_CNT; i++) begin : g_credit
        ibuf_credit_counter u_credit (
            .clk   (clk),
            .rst_n (rst_n),
            .incr  (sched_fire && (sched_isw == fetch_pkg::isw_t'(i))),
            .decr  (ibuf_pop[i]),
            .full  (slice_full[i])
        );
    end

    warp_tag_store u_tag_store (
        .clk    (clk),
        .we     (sched_fire),
        .waddr  (sched_wid),
        .wpc    (sched_pc),
        .wtmask (sched_tmask),
        .raddr  (rsp_wid),
        .rpc    (fetch_pc),
        .rtmask (fetch_tmask)
    );

    // Registered request toward the memory
    fetch_req_buffer u_req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sched_valid && ibuf_ready),
        .in_ready  (buf_in_ready),
        .in_addr   (sched_pc[fetch_pkg::XLEN-1:2]),
        .in_tag    ({sched_uuid, sched_wid}),
        .out_valid (mem_req_valid),
        .out_ready (mem_req_ready),
        .out_addr  (mem_req_addr),
        .out_tag   (mem_req_tag)
    );

    // Split the response tag and rejoin PC and tmask
    assign rsp_wid       = mem_rsp_tag[fetch_pkg::WID_W-1:0];
    assign fetch_uuid    = mem_rsp_tag[fetch_pkg::TAG_W-1:fetch_pkg::WID_W];
    assign fetch_wid     = rsp_wid;
    assign fetch_instr   = mem_rsp_data;
    assign fetch_valid   = mem_rsp_valid;
    assign mem_rsp_ready = fetch_ready;

endmodule

/* logic/fetch_req_buffer.sv */
`timescale 1ns/1ps

module fetch_req_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  fetch_pkg::imem_addr_t in_addr,
    input  fetch_pkg::imem_tag_t  in_tag,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::imem_addr_t out_addr,
    output fetch_pkg::imem_tag_t  out_tag
);

    logic                  skid_valid;
    fetch_pkg::imem_addr_t skid_addr;
    fetch_pkg::imem_tag_t  skid_tag;
    logic                  in_fire;
    logic                  out_load;

    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    // Output register is free or is handing its entry over this cycle
    assign out_load = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid  <= skid_valid || in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                // Park the new entry while the output is stalled
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_addr <= skid_addr;
                out_tag  <= skid_tag;
            end else if (in_fire) begin
                out_addr <= in_addr;
                out_tag  <= in_tag;
            end
        end else if (in_fire) begin
            skid_addr <= in_addr;
            skid_tag  <= in_tag;
        end
    end

endmodule

/* logic/ibuf_credit_counter.sv */
`timescale 1ns/1ps

module ibuf_credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic incr,
    input  logic decr,
    output logic full
);

    fetch_pkg::credit_t count;

    // Fetches in flight plus entries sitting in the slice's instruction buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            if (incr && !decr) begin
                count <= count + fetch_pkg::credit_t'(1);
            end else if (decr && !incr) begin
                count <= count - fetch_pkg::credit_t'(1);
            end
        end
    end

    // No room left for another instruction in this slice
    assign full = (count == fetch_pkg::credit_t'(fetch_pkg::IBUF_SIZE));

endmodule

/* logic/warp_tag_store.sv */
`timescale 1ns/1ps

module warp_tag_store (
    input  logic              clk,
    input  logic              we,
    input  fetch_pkg::wid_t   waddr,
    input  fetch_pkg::pc_t    wpc,
    input  fetch_pkg::tmask_t wtmask,
    input  fetch_pkg::wid_t   raddr,
    output fetch_pkg::pc_t    rpc,
    output fetch_pkg::tmask_t rtmask
);

    // One PC and thread mask slot per warp
    fetch_pkg::pc_t    pc_mem    [fetch_pkg::NUM_WARPS];
    fetch_pkg::tmask_t tmask_mem [fetch_pkg::NUM_WARPS];

    always_ff @(posedge clk) begin
        if (we) begin
            pc_mem[waddr]    <= wpc;
            tmask_mem[waddr] <= wtmask;
        end
    end

    // Asynchronous read by the wid of the returning tag
    assign rpc    = pc_mem[raddr];
    assign rtmask = tmask_mem[raddr];

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // Core shape
    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;
    localparam int ISSUE_CNT   = 2;
    localparam int IBUF_SIZE   = 2;
    localparam int IMEM_DEPTH  = 16;

    // Derived widths
    localparam int WID_W       = $clog2(NUM_WARPS);
    localparam int ISW_W       = $clog2(ISSUE_CNT);
    localparam int UUID_W      = 8;
    localparam int XLEN        = 32;
    localparam int IMEM_ADDR_W = XLEN - 2;
    localparam int IMEM_IDX_W  = $clog2(IMEM_DEPTH);
    localparam int TAG_W       = UUID_W + WID_W;
    localparam int CREDIT_W    = $clog2(IBUF_SIZE + 1);

    typedef logic [WID_W-1:0]       wid_t;
    typedef logic [ISW_W-1:0]       isw_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [XLEN-1:0]        pc_t;
    typedef logic [XLEN-1:0]        instr_t;
    typedef logic [UUID_W-1:0]      uuid_t;
    // Word address made of PC bits 31 to 2
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
    // {uuid, wid}
    typedef logic [TAG_W-1:0]       imem_tag_t;
    typedef logic [CREDIT_W-1:0]    credit_t;

endpackage
